//--- sim/bridge_cases.txt
// cmd(0 read, 1 write) width(0 byte, 1 hword, 2 word) addr wdata exp_rdata
// exp_resp(1 ok, 2 err), all hex
1 2 00000000 11223344 00000000 1
0 2 00000000 00000000 11223344 1
1 0 00000001 000000aa 00000000 1
1 0 00000003 000000bb 00000000 1
0 0 00000000 00000000 bb22aa44 1
0 0 00000001 00000000 00bb22aa 1
0 0 00000002 00000000 0000bb22 1
0 0 00000003 00000000 000000bb 1
1 2 00000004 55667788 00000000 1
1 1 00000006 0000cafe 00000000 1
1 1 00000004 0000beef 00000000 1
0 1 00000004 00000000 cafebeef 1
0 1 00000006 00000000 0000cafe 1
1 0 00000006 000000d1 00000000 1
0 2 00000004 00000000 cad1beef 1
1 2 00000100 deadbeef 00000000 2
0 2 00000100 00000000 00000000 2
0 2 00000004 00000000 cad1beef 1
1 2 000000fc 0badf00d 00000000 1
0 0 000000fe 00000000 00000bad 1
0 2 00000200 00000000 00000000 2
1 2 00000008 00000000 00000000 1
1 0 00000008 ffffff12 00000000 1
0 2 00000008 00000000 00000012 1
0 1 000000fe 00000000 00000bad 1

//--- flist.f
logic/mem_axi_pkg.sv
logic/req_tracker.sv
logic/req_store.sv
logic/axi_issue.sv
logic/resp_collect.sv
logic/mem_axi_bridge.sv
sim/axi_mem_model.sv
sim/tb_mem_axi_bridge.sv

//--- Makefile
SIM     := verilator
TOP     := tb_mem_axi_bridge
FLIST   := flist.f
OBJ_DIR := obj_dir
FLAGS   := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)

SRCS    := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_mem_axi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_axi_bridge;

    import mem_axi_pkg::*;

    localparam int clk_period   = 40;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 8;
    localparam int max_cases    = 64;
    // cmd, width, addr, wdata, rdata, resp
    localparam int case_fields  = 6;

    logic              clk;
    logic              rst_n;
    logic              core_req;
    mem_cmd_e          core_cmd;
    mem_width_e        core_width;
    logic [addr_w-1:0] core_addr;
    logic [data_w-1:0] core_wdata;
    logic              core_req_ack;
    mem_resp_e         core_resp;
    logic [data_w-1:0] core_rdata;
    logic              core_idle;
    logic [addr_w-1:0] awaddr;
    logic [2:0]        awsize;
    logic              awvalid;
    logic              awready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              bready;
    logic [addr_w-1:0] araddr;
    logic [2:0]        arsize;
    logic              arvalid;
    logic              arready;
    logic              rvalid;
    logic [1:0]        rresp;
    logic [data_w-1:0] rdata;
    logic              rready;

    logic [31:0]       case_mem [max_cases*case_fields];
    int                num_cases;
    int                timeout_limit = 100;
    int                cycle_cnt = 0;
    int                accept_cnt = 0;
    int                done_cnt = 0;
    int                ack_low_cycles = 0;
    // Case indices accepted by the DUT, oldest first
    int                exp_q [$];
    // Accepted cases whose address phase is still to come
    int                issue_q [$];
    logic              monitor_on = 1'b0;
    logic              hs_prev = 1'b0;
    logic              aw_stall = 1'b0;
    logic              w_stall = 1'b0;
    logic              ar_stall = 1'b0;
    logic [31:0]       awaddr_prev;
    logic [31:0]       wdata_prev;
    logic [3:0]        wstrb_prev;
    logic [31:0]       araddr_prev;

    mem_axi_bridge dut (.*);

    axi_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            stop_with_failure($sformatf("mismatch on %s at %0t", name, $time));
        end
    endtask

    task automatic check_reset_state();
        compare("awvalid", 32'(awvalid), 32'h0);
        compare("wvalid", 32'(wvalid), 32'h0);
        compare("arvalid", 32'(arvalid), 32'h0);
        compare("bready", 32'(bready), 32'h0);
        compare("rready", 32'(rready), 32'h0);
        compare("core_resp", 32'(core_resp), 32'(resp_notrdy));
        compare("core_idle", 32'(core_idle), 32'h1);
        compare("core_req_ack", 32'(core_req_ack), 32'h1);
    endtask

    // Log2 of the bytes moved: 1, 2 or 4
    function automatic logic [31:0] expected_axsize(input logic [31:0] width_code);
        logic [31:0] size;
        case (width_code)
            32'h0:   size = 32'h0;
            32'h1:   size = 32'h1;
            default: size = 32'h2;
        endcase
        return size;
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            stop_with_failure($sformatf("timeout: run still busy after %0d cycles", cycle_cnt));
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int c;
        int base;
        rst_n      = 1'b0;
        core_req   = 1'b0;
        core_cmd   = cmd_read;
        core_width = width_byte;
        core_addr  = '0;
        core_wdata = '0;
        // All ones marks the end of the case list
        for (c = 0; c < max_cases * case_fields; c++) begin
            case_mem[c] = '1;
        end
        $readmemh("sim/bridge_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < max_cases && case_mem[num_cases*case_fields] != 32'hffff_ffff) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            stop_with_failure("no cases found in sim/bridge_cases.txt");
        end
        timeout_limit = 40 * num_cases + 100;

        for (c = 0; c < reset_cycles - 1; c++) begin
            @(negedge clk);
            check_reset_state();
        end
        @(posedge clk);
        #drive_delay;
        rst_n      = 1'b1;
        monitor_on = 1'b1;
        @(negedge clk);
        check_reset_state();

        @(posedge clk);
        #drive_delay;
        for (c = 0; c < num_cases; c++) begin
            base       = c * case_fields;
            core_req   = 1'b1;
            core_cmd   = mem_cmd_e'(case_mem[base][0]);
            core_width = mem_width_e'(case_mem[base+1][1:0]);
            core_addr  = case_mem[base+2];
            core_wdata = case_mem[base+3];
            @(negedge clk);
            while (!core_req_ack) begin
                @(negedge clk);
            end
            @(posedge clk);
            #drive_delay;
        end
        core_req = 1'b0;

        wait (done_cnt == num_cases);
        @(negedge clk);
        compare("core_idle", 32'(core_idle), 32'h1);
        compare("core_req_ack ever low", 32'(ack_low_cycles != 0), 32'h1);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    ////////////////////
    // Response and protocol monitor
    ////////////////////

    // Sampled at the falling edge, halfway between input changes and the next rising edge
    always @(negedge clk) begin : monitor
        int   idx;
        logic hs_now;
        if (monitor_on) begin
            hs_now = (bvalid && bready) || (rvalid && rready);
            // One registered stage after B or R
            compare("core_resp valid", 32'(core_resp != resp_notrdy), 32'(hs_prev));
            hs_prev = hs_now;

            if (core_resp != resp_notrdy) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("core response arrived with no request outstanding");
                end else begin
                    idx = exp_q.pop_front() * case_fields;
                    compare("core_resp", 32'(core_resp), case_mem[idx+5]);
                    if (case_mem[idx] == 32'h0 && case_mem[idx+5] == 32'(resp_ok)) begin
                        compare("core_rdata", core_rdata, case_mem[idx+4]);
                    end
                    done_cnt++;
                end
            end

            compare("core_idle", 32'(core_idle), 32'(exp_q.size() == 0));
            compare("core_req_ack", 32'(core_req_ack), 32'(exp_q.size() < req_depth));
            if (!core_req_ack) begin
                ack_low_cycles++;
            end

            // Response channel opens for the oldest pending request only
            if (exp_q.size() != 0) begin
                idx = exp_q[0] * case_fields;
                compare("bready", 32'(bready), 32'(case_mem[idx] == 32'h1));
                compare("rready", 32'(rready), 32'(case_mem[idx] == 32'h0));
            end else begin
                compare("bready", 32'(bready), 32'h0);
                compare("rready", 32'(rready), 32'h0);
            end

            // Address phases go out in request order
            if ((awvalid && awready) || (arvalid && arready)) begin
                if (issue_q.size() == 0) begin
                    stop_with_failure("address handshake with no request waiting to issue");
                end else begin
                    idx = issue_q.pop_front() * case_fields;
                    compare("awvalid", 32'(awvalid), 32'(case_mem[idx] == 32'h1));
                    compare("arvalid", 32'(arvalid), 32'(case_mem[idx] == 32'h0));
                    if (awvalid) begin
                        compare("awaddr", awaddr, case_mem[idx+2]);
                        compare("awsize", 32'(awsize), expected_axsize(case_mem[idx+1]));
                    end else begin
                        compare("araddr", araddr, case_mem[idx+2]);
                        compare("arsize", 32'(arsize), expected_axsize(case_mem[idx+1]));
                    end
                end
            end

            // Stalled channels hold valid and payload
            if (aw_stall) begin
                compare("awvalid", 32'(awvalid), 32'h1);
                compare("awaddr", awaddr, awaddr_prev);
            end
            if (w_stall) begin
                compare("wvalid", 32'(wvalid), 32'h1);
                compare("wdata", wdata, wdata_prev);
                compare("wstrb", 32'(wstrb), 32'(wstrb_prev));
            end
            if (ar_stall) begin
                compare("arvalid", 32'(arvalid), 32'h1);
                compare("araddr", araddr, araddr_prev);
            end
            aw_stall    = awvalid && !awready;
            w_stall     = wvalid && !wready;
            ar_stall    = arvalid && !arready;
            awaddr_prev = awaddr;
            wdata_prev  = wdata;
            wstrb_prev  = wstrb;
            araddr_prev = araddr;

            if (core_req && core_req_ack) begin
                exp_q.push_back(accept_cnt);
                issue_q.push_back(accept_cnt);
                accept_cnt++;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    output logic [1:0]  rresp,
    output logic [31:0] rdata,
    input  logic        rready
);

    // Addresses from here up answer with SLVERR
    localparam logic [31:0] mem_limit = 32'h100;
    localparam logic [31:0] seed      = 32'h999e0eae;

    logic [31:0] mem [64];
    logic [31:0] rng;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic [1:0]  ar_wait;
    logic [1:0]  resp_wait;
    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    // {is_read, resp, data}, oldest first
    logic [34:0] resp_q [$];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        arready = 1'b0;
        bvalid  = 1'b0;
        bresp   = 2'b00;
        rvalid  = 1'b0;
        rresp   = 2'b00;
        rdata   = 32'h0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'ha500_0000 ^ (i * 32'h0001_0203);
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= 2'b00;
            rvalid  <= 1'b0;
            rresp   <= 2'b00;
            rdata   <= 32'h0;
            rng       = seed;
            aw_wait   = 2'd0;
            w_wait    = 2'd0;
            ar_wait   = 2'd0;
            resp_wait = 2'd0;
            aw_got    = 1'b0;
            w_got     = 1'b0;
            resp_q.delete();
        end else begin
            ////////////////////
            // Write address and data
            ////////////////////
            if (awvalid && awready) begin
                aw_addr_q = awaddr;
                aw_got    = 1'b1;
                awready  <= 1'b0;
                rng       = xorshift32(rng);
                aw_wait   = rng[1:0];
            end else if (awvalid) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait = aw_wait - 2'd1;
                end
            end

            if (wvalid && wready) begin
                w_data_q = wdata;
                w_strb_q = wstrb;
                w_got    = 1'b1;
                wready  <= 1'b0;
                rng      = xorshift32(rng);
                w_wait   = rng[1:0];
            end else if (wvalid) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait = w_wait - 2'd1;
                end
            end

            // Commit once both halves of the write are in
            if (aw_got && w_got) begin
                if (aw_addr_q < mem_limit) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb_q[b]) begin
                            mem[aw_addr_q[7:2]][8*b +: 8] = w_data_q[8*b +: 8];
                        end
                    end
                    resp_q.push_back({1'b0, 2'b00, 32'h0});
                end else begin
                    resp_q.push_back({1'b0, 2'b10, 32'h0});
                end
                aw_got = 1'b0;
                w_got  = 1'b0;
            end

            ////////////////////
            // Read address
            ////////////////////
            if (arvalid && arready) begin
                arready <= 1'b0;
                rng      = xorshift32(rng);
                ar_wait  = rng[1:0];
                if (araddr < mem_limit) begin
                    resp_q.push_back({1'b1, 2'b00, mem[araddr[7:2]]});
                end else begin
                    resp_q.push_back({1'b1, 2'b10, 32'h0});
                end
            end else if (arvalid) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait = ar_wait - 2'd1;
                end
            end

            ////////////////////
            // Responses, strictly in order
            ////////////////////
            if ((bvalid && bready) || (rvalid && rready)) begin
                void'(resp_q.pop_front());
                bvalid   <= 1'b0;
                rvalid   <= 1'b0;
                rng       = xorshift32(rng);
                resp_wait = rng[1:0];
            end else if (!bvalid && !rvalid && resp_q.size() != 0) begin
                if (resp_wait != 2'd0) begin
                    resp_wait = resp_wait - 2'd1;
                end else if (resp_q[0][34]) begin
                    rvalid <= 1'b1;
                    rresp  <= resp_q[0][33:32];
                    rdata  <= resp_q[0][31:0];
                end else begin
                    bvalid <= 1'b1;
                    bresp  <= resp_q[0][33:32];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_axi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module mem_axi_bridge (
    input  logic                              clk,
    input  logic                              rst_n,

    // Core request port
    input  logic                              core_req,
    input  mem_axi_pkg::mem_cmd_e             core_cmd,
    input  mem_axi_pkg::mem_width_e           core_width,
    input  logic [mem_axi_pkg::addr_w-1:0]    core_addr,
    input  logic [mem_axi_pkg::data_w-1:0]    core_wdata,
    output logic                              core_req_ack,
    output mem_axi_pkg::mem_resp_e            core_resp,
    output logic [mem_axi_pkg::data_w-1:0]    core_rdata,
    output logic                              core_idle,

    // AXI write address and data
    output logic [mem_axi_pkg::addr_w-1:0]    awaddr,
    output logic [2:0]                        awsize,
    output logic                              awvalid,
    input  logic                              awready,
    output logic [mem_axi_pkg::data_w-1:0]    wdata,
    output logic [mem_axi_pkg::strb_w-1:0]    wstrb,
    output logic                              wvalid,
    input  logic                              wready,

    // AXI write response
    input  logic                              bvalid,
    input  logic [1:0]                        bresp,
    output logic                              bready,

    // AXI read address and data
    output logic [mem_axi_pkg::addr_w-1:0]    araddr,
    output logic [2:0]                        arsize,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic                              rvalid,
    input  logic [1:0]                        rresp,
    input  logic [mem_axi_pkg::data_w-1:0]    rdata,
    output logic                              rready
);

    import mem_axi_pkg::*;

    logic             accept;
    logic [ptr_w-1:0] accept_ptr;
    logic [ptr_w-1:0] issue_ptr;
    logic [ptr_w-1:0] done_ptr;
    req_entry_t       issue_entry;
    mem_width_e       done_width;
    logic [1:0]       done_offset;

    ////////////////////
    // Slot status and pointers
    ////////////////////

    req_tracker #(
        .depth (req_depth)
    ) u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_req     (core_req),
        .core_cmd     (core_cmd),
        .awready      (awready),
        .wready       (wready),
        .arready      (arready),
        .bvalid       (bvalid),
        .rvalid       (rvalid),
        .core_req_ack (core_req_ack),
        .core_idle    (core_idle),
        .accept       (accept),
        .accept_ptr   (accept_ptr),
        .issue_ptr    (issue_ptr),
        .done_ptr     (done_ptr),
        .awvalid      (awvalid),
        .wvalid       (wvalid),
        .arvalid      (arvalid),
        .bready       (bready),
        .rready       (rready)
    );

    // Payload slots, steered by the tracker pointers
    req_store #(
        .depth (req_depth)
    ) u_store (
        .clk         (clk),
        .accept      (accept),
        .accept_ptr  (accept_ptr),
        .issue_ptr   (issue_ptr),
        .done_ptr    (done_ptr),
        .core_width  (core_width),
        .core_addr   (core_addr),
        .core_wdata  (core_wdata),
        .issue_entry (issue_entry),
        .done_width  (done_width),
        .done_offset (done_offset)
    );

    ////////////////////
    // AXI side
    ////////////////////

    axi_issue u_issue (
        .issue_entry (issue_entry),
        .awaddr      (awaddr),
        .araddr      (araddr),
        .awsize      (awsize),
        .arsize      (arsize),
        .wstrb       (wstrb),
        .wdata       (wdata)
    );

    resp_collect u_resp (
        .clk         (clk),
        .rst_n       (rst_n),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .rresp       (rresp),
        .rdata       (rdata),
        .done_width  (done_width),
        .done_offset (done_offset),
        .core_resp   (core_resp),
        .core_rdata  (core_rdata)
    );

endmodule

`default_nettype wire

//--- logic/resp_collect.sv
`timescale 1ns/10ps
`default_nettype none

module resp_collect (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            bvalid,
    input  logic                            bready,
    input  logic [1:0]                      bresp,
    input  logic                            rvalid,
    input  logic                            rready,
    input  logic [1:0]                      rresp,
    input  logic [mem_axi_pkg::data_w-1:0]  rdata,
    input  mem_axi_pkg::mem_width_e         done_width,
    input  logic [1:0]                      done_offset,
    output mem_axi_pkg::mem_resp_e          core_resp,
    output logic [mem_axi_pkg::data_w-1:0]  core_rdata
);

    import mem_axi_pkg::*;

    logic              b_hs;
    logic              r_hs;
    mem_resp_e         resp_nxt;
    logic [data_w-1:0] rdata_aligned;

    assign b_hs = bvalid & bready;
    assign r_hs = rvalid & rready;

    // Only one of B and R can be open at a time
    always_comb begin
        if (b_hs) begin
            resp_nxt = (bresp == axi_resp_okay) ? resp_ok : resp_err;
        end else if (r_hs) begin
            resp_nxt = (rresp == axi_resp_okay) ? resp_ok : resp_err;
        end else begin
            resp_nxt = resp_notrdy;
        end
    end

    // Right-align read data, upper bytes left as received
    always_comb begin
        case (done_width)
            width_byte, width_hword, width_word:
                rdata_aligned = rdata >> {done_offset, 3'b000};
            default:
                rdata_aligned = rdata;
        endcase
    end

    ////////////////////
    // Output stage
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_resp <= resp_notrdy;
        end else begin
            core_resp <= resp_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (r_hs) begin
            core_rdata <= rdata_aligned;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_issue.sv
`timescale 1ns/10ps
`default_nettype none

module axi_issue (
    input  mem_axi_pkg::req_entry_t         issue_entry,
    output logic [mem_axi_pkg::addr_w-1:0]  awaddr,
    output logic [mem_axi_pkg::addr_w-1:0]  araddr,
    output logic [2:0]                      awsize,
    output logic [2:0]                      arsize,
    output logic [mem_axi_pkg::strb_w-1:0]  wstrb,
    output logic [mem_axi_pkg::data_w-1:0]  wdata
);

    import mem_axi_pkg::*;

    logic [1:0]        offset;
    logic [strb_w-1:0] width_mask;

    assign offset = issue_entry.addr[1:0];

    ////////////////////
    // Address channels
    ////////////////////

    assign awaddr = issue_entry.addr;
    assign araddr = issue_entry.addr;
    assign awsize = width_to_axsize(issue_entry.width);
    assign arsize = width_to_axsize(issue_entry.width);

    ////////////////////
    // Write lanes
    ////////////////////

    // Bytes covered by the access before lane placement
    always_comb begin
        case (issue_entry.width)
            width_byte:  width_mask = 4'h1;
            width_hword: width_mask = 4'h3;
            width_word:  width_mask = 4'hf;
            default:     width_mask = 4'h0;
        endcase
    end

    assign wstrb = width_mask << offset;

    // Core data is right-aligned, move it up to its byte lane
    assign wdata = issue_entry.wdata << {offset, 3'b000};

endmodule

`default_nettype wire

//--- logic/req_store.sv
`timescale 1ns/10ps
`default_nettype none

module req_store #(
    parameter int depth = mem_axi_pkg::req_depth
) (
    input  logic                            clk,
    input  logic                            accept,
    input  logic [mem_axi_pkg::ptr_w-1:0]   accept_ptr,
    input  logic [mem_axi_pkg::ptr_w-1:0]   issue_ptr,
    input  logic [mem_axi_pkg::ptr_w-1:0]   done_ptr,
    input  mem_axi_pkg::mem_width_e         core_width,
    input  logic [mem_axi_pkg::addr_w-1:0]  core_addr,
    input  logic [mem_axi_pkg::data_w-1:0]  core_wdata,
    output mem_axi_pkg::req_entry_t         issue_entry,
    output mem_axi_pkg::mem_width_e         done_width,
    output logic [1:0]                      done_offset
);

    import mem_axi_pkg::*;

    req_entry_t slots [depth];

    always_ff @(posedge clk) begin
        if (accept) begin
            slots[accept_ptr].width <= core_width;
            slots[accept_ptr].addr  <= core_addr;
            slots[accept_ptr].wdata <= core_wdata;
        end
    end

    // Entry on the bus now
    assign issue_entry = slots[issue_ptr];

    // Oldest entry still waiting for B or R
    assign done_width  = slots[done_ptr].width;
    assign done_offset = slots[done_ptr].addr[1:0];

endmodule

`default_nettype wire

//--- logic/req_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module req_tracker #(
    parameter int depth = mem_axi_pkg::req_depth
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            core_req,
    input  mem_axi_pkg::mem_cmd_e           core_cmd,

    input  logic                            awready,
    input  logic                            wready,
    input  logic                            arready,
    input  logic                            bvalid,
    input  logic                            rvalid,

    output logic                            core_req_ack,
    output logic                            core_idle,
    output logic                            accept,
    output logic [mem_axi_pkg::ptr_w-1:0]   accept_ptr,
    output logic [mem_axi_pkg::ptr_w-1:0]   issue_ptr,
    output logic [mem_axi_pkg::ptr_w-1:0]   done_ptr,

    output logic                            awvalid,
    output logic                            wvalid,
    output logic                            arvalid,
    output logic                            bready,
    output logic                            rready
);

    import mem_axi_pkg::*;

    // Per-slot flags
    logic [depth-1:0] slot_write;
    logic [depth-1:0] slot_addr;
    logic [depth-1:0] slot_data;
    logic [depth-1:0] slot_resp;

    logic [depth-1:0] write_nxt;
    logic [depth-1:0] addr_nxt;
    logic [depth-1:0] data_nxt;
    logic [depth-1:0] resp_nxt;

    logic addr_hs;
    logic data_hs;
    logic resp_hs;
    logic addr_left;
    logic data_left;
    logic issue_adv;

    ////////////////////
    // Core side
    ////////////////////

    // A slot is free again once its response has been collected
    assign core_req_ack = ~slot_resp[accept_ptr];
    assign accept       = core_req & core_req_ack;
    assign core_idle    = ~|slot_resp;

    ////////////////////
    // AXI controls
    ////////////////////

    assign awvalid = slot_addr[issue_ptr] &  slot_write[issue_ptr];
    assign arvalid = slot_addr[issue_ptr] & ~slot_write[issue_ptr];
    assign wvalid  = slot_data[issue_ptr] &  slot_write[issue_ptr];

    // Oldest pending slot decides which response channel is open
    assign bready = slot_resp[done_ptr] &  slot_write[done_ptr];
    assign rready = slot_resp[done_ptr] & ~slot_write[done_ptr];

    assign addr_hs = (awvalid & awready) | (arvalid & arready);
    assign data_hs = wvalid & wready;
    assign resp_hs = (bvalid & bready) | (rvalid & rready);

    // AW and W may finish in either order
    assign addr_left = slot_addr[issue_ptr] & ~addr_hs;
    assign data_left = slot_data[issue_ptr] & ~data_hs;
    assign issue_adv = (addr_hs | data_hs) & ~addr_left & ~data_left;

    ////////////////////
    // Flag updates
    ////////////////////

    always_comb begin
        write_nxt = slot_write;
        addr_nxt  = slot_addr;
        data_nxt  = slot_data;
        resp_nxt  = slot_resp;

        if (accept) begin
            write_nxt[accept_ptr] = (core_cmd == cmd_write);
            addr_nxt[accept_ptr]  = 1'b1;
            data_nxt[accept_ptr]  = (core_cmd == cmd_write);
            resp_nxt[accept_ptr]  = 1'b1;
        end

        if (addr_hs) begin
            addr_nxt[issue_ptr] = 1'b0;
        end
        if (data_hs) begin
            data_nxt[issue_ptr] = 1'b0;
        end
        if (resp_hs) begin
            resp_nxt[done_ptr] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_write <= '0;
            slot_addr  <= '0;
            slot_data  <= '0;
            slot_resp  <= '0;
        end else begin
            slot_write <= write_nxt;
            slot_addr  <= addr_nxt;
            slot_data  <= data_nxt;
            slot_resp  <= resp_nxt;
        end
    end

    // Three pointers, each on its own event
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accept_ptr <= '0;
            issue_ptr  <= '0;
            done_ptr   <= '0;
        end else begin
            if (accept) begin
                accept_ptr <= accept_ptr + 1'b1;
            end
            if (issue_adv) begin
                issue_ptr <= issue_ptr + 1'b1;
            end
            if (resp_hs) begin
                done_ptr <= done_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_axi_pkg.sv
`default_nettype none

package mem_axi_pkg;

    ////////////////////
    // Bus widths and queue depth
    ////////////////////

    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int strb_w    = data_w / 8;
    // Must stay a power of two so the pointers wrap on their own
    localparam int req_depth = 2;
    localparam int ptr_w     = $clog2(req_depth);

    // Only OKAY counts as success
    localparam logic [1:0] axi_resp_okay = 2'b00;

    ////////////////////
    // Core port encodings
    ////////////////////

    typedef enum logic {
        cmd_read  = 1'b0,
        cmd_write = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        width_byte  = 2'b00,
        width_hword = 2'b01,
        width_word  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        resp_notrdy = 2'b00,
        resp_ok     = 2'b01,
        resp_err    = 2'b10
    } mem_resp_e;

    // One queued request, 66 bits
    typedef struct packed {
        mem_width_e          width;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
    } req_entry_t;

    // AXI size is log2 of the byte count
    function automatic logic [2:0] width_to_axsize(input mem_width_e width);
        logic [2:0] size;
        case (width)
            width_byte:  size = 3'd0;
            width_hword: size = 3'd1;
            width_word:  size = 3'd2;
            default:     size = 3'd2;
        endcase
        return size;
    endfunction

endpackage

`default_nettype wire
